// ==== Makefile ====
# Verilator build and run of the execute stage testbench
TOP := tb_ooo_execute

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== logic/arith_unit.sv ====
/* Single-cycle integer ALU for the execute stage.
   Result and valid are combinational and registered by the commit latch. */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_exec_cfg.svh"

module arith_unit (
  exec_op_if.unit                   op,
  output logic                      valid,
  output ooo_exec_pkg::au_result_t  result
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0]  shamt;
  ooo_exec_pkg::word_t wdata;

  // Only the low bits of port_b count for shifts
  assign shamt = op.port_b[SHAMT_W-1:0];

  always_comb begin
    case (op.alu_op)
      ooo_exec_pkg::ADD:  wdata = op.port_a + op.port_b;
      ooo_exec_pkg::SUB:  wdata = op.port_a - op.port_b;
      ooo_exec_pkg::AND:  wdata = op.port_a & op.port_b;
      ooo_exec_pkg::OR:   wdata = op.port_a | op.port_b;
      ooo_exec_pkg::XOR:  wdata = op.port_a ^ op.port_b;
      ooo_exec_pkg::SLL:  wdata = op.port_a << shamt;
      ooo_exec_pkg::SRL:  wdata = op.port_a >> shamt;
      ooo_exec_pkg::SRA:  wdata = ooo_exec_pkg::word_t'($signed(op.port_a) >>> shamt);
      ooo_exec_pkg::SLT:  wdata = ooo_exec_pkg::word_t'($signed(op.port_a) < $signed(op.port_b));
      ooo_exec_pkg::SLTU: wdata = ooo_exec_pkg::word_t'(op.port_a < op.port_b);
      default:            wdata = '0;
    endcase
  end

  assign valid         = op.issue_au;
  assign result.wdata  = wdata;
  assign result.reg_rd = op.reg_rd;
  assign result.index  = op.index;

  // Decode must never hand over an unused encoding
  always_comb begin
    if (op.issue_au) begin
      a_alu_op_legal: assert final (op.alu_op <= ooo_exec_pkg::SLTU)
        else $error("arith_unit: illegal alu_op %0d issued", op.alu_op);
    end
  end

endmodule

`default_nettype wire

// ==== logic/branch_jump_res.sv ====
/* Branch and jump resolution for the execute stage.
   Mispredict and redirect address go straight to the hazard unit in the issue
   cycle, the predictor update record goes to the commit latch. */
`timescale 1ns/1ps
`default_nettype none

module branch_jump_res (
  exec_op_if.unit                   op,
  output logic                      valid,
  output ooo_exec_pkg::br_result_t  result,
  output logic                      mispredict,
  output ooo_exec_pkg::word_t       brj_addr
);

  logic                taken;
  logic                br_mispredict;
  ooo_exec_pkg::word_t br_target;
  ooo_exec_pkg::word_t pc4;
  ooo_exec_pkg::word_t jump_base;
  ooo_exec_pkg::word_t jump_addr;

  // Branch condition
  always_comb begin
    case (op.br_op)
      ooo_exec_pkg::BEQ:  taken = (op.port_a == op.port_b);
      ooo_exec_pkg::BNE:  taken = (op.port_a != op.port_b);
      ooo_exec_pkg::BLT:  taken = ($signed(op.port_a) < $signed(op.port_b));
      ooo_exec_pkg::BGE:  taken = ($signed(op.port_a) >= $signed(op.port_b));
      ooo_exec_pkg::BLTU: taken = (op.port_a < op.port_b);
      ooo_exec_pkg::BGEU: taken = (op.port_a >= op.port_b);
      default:            taken = 1'b0;
    endcase
  end

  assign br_target = op.pc + op.imm;
  assign pc4       = op.pc + ooo_exec_pkg::word_t'(4);

  // JALR adds to rs1, JAL to pc
  assign jump_base = op.j_sel ? op.port_a : op.pc;
  assign jump_addr = (jump_base + op.imm) & ~ooo_exec_pkg::word_t'(1);

  assign br_mispredict = op.issue_br & (op.prediction ^ taken);
  assign mispredict    = op.issue_jump | br_mispredict;

  // Jumps always redirect, branches only when the guess was wrong
  assign brj_addr = op.issue_jump ? jump_addr :
                    br_mispredict ? br_target : pc4;

  assign valid                = op.issue_br | op.issue_jump;
  assign result.is_jump       = op.issue_jump;
  assign result.taken         = taken;
  assign result.prediction    = op.prediction;
  assign result.resolved_addr = taken ? br_target : pc4;
  assign result.jump_addr     = jump_addr;
  assign result.pc4           = pc4;

  // Issue logic sends a branch or a jump per cycle, never both
  always_comb begin
    a_one_control_op: assert final (!(op.issue_br && op.issue_jump))
      else $error("branch_jump_res: branch and jump issued together");
  end

endmodule

`default_nettype wire

// ==== logic/commit_latch.sv ====
/* Execute/commit register for one result path.
   Flush or an execute-only stall inserts a bubble, a commit stall holds. */
`timescale 1ns/1ps
`default_nettype none

module commit_latch #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     stall_ex,
  input  logic     stall_commit,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic bubble;

  assign bubble = flush | (stall_ex & ~stall_commit);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else if (bubble) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else if (!stall_commit) begin
      out_valid <= in_valid;
      out_data  <= in_data;
    end
  end

  // Flush has priority over a held commit stage
  a_flush_clears: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !out_valid)
    else $error("commit_latch: result still valid after flush");

endmodule

`default_nettype wire

// ==== logic/exec_op_if.sv ====
/* Issued operation as seen by the execute units.
   Driven once at the top level and read by every unit. */
`timescale 1ns/1ps
`default_nettype none

interface exec_op_if;

  // Issue strobes, one cycle each
  logic                      issue_au;
  logic                      issue_mu;
  logic                      issue_br;
  logic                      issue_jump;

  // Operation select
  logic                      j_sel;
  ooo_exec_pkg::alu_op_t     alu_op;
  ooo_exec_pkg::mul_op_t     mul_op;
  ooo_exec_pkg::br_op_t      br_op;
  logic                      prediction;

  // Operands and destination
  ooo_exec_pkg::word_t       port_a;
  ooo_exec_pkg::word_t       port_b;
  ooo_exec_pkg::word_t       pc;
  ooo_exec_pkg::word_t       imm;
  ooo_exec_pkg::reg_addr_t   reg_rd;
  ooo_exec_pkg::cb_index_t   index;

  modport unit (
    input issue_au, issue_mu, issue_br, issue_jump, j_sel, alu_op, mul_op, br_op,
          prediction, port_a, port_b, pc, imm, reg_rd, index
  );

  // Driver side view
  modport source (
    output issue_au, issue_mu, issue_br, issue_jump, j_sel, alu_op, mul_op, br_op,
           prediction, port_a, port_b, pc, imm, reg_rd, index
  );

endinterface

`default_nettype wire

// ==== logic/multiply_unit.sv ====
/* Pipelined multiplier for the execute stage.
   The full product is formed in the first stage and carried with its
   destination tags to the last, which feeds the commit latch. */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_exec_cfg.svh"

module multiply_unit (
  input  logic                      CLK,
  input  logic                      nRST,
  exec_op_if.unit                   op,
  input  logic                      advance,
  input  logic                      flush,
  output logic                      valid,
  output ooo_exec_pkg::mu_result_t  result,
  output logic                      busy_mu
);

  localparam int DEPTH  = `MUL_LATENCY;
  localparam int PROD_W = 2 * `XLEN;

  logic                    sign_a;
  logic                    sign_b;
  logic [PROD_W-1:0]       a_ext;
  logic [PROD_W-1:0]       b_ext;
  logic [PROD_W-1:0]       product;
  logic [DEPTH-1:0]        stage_valid;
  logic [DEPTH-1:0]        stage_hi;
  logic [PROD_W-1:0]       stage_prod [DEPTH];
  ooo_exec_pkg::reg_addr_t stage_rd   [DEPTH];
  ooo_exec_pkg::cb_index_t stage_idx  [DEPTH];

  // MUL takes the low word, so its extension choice does not matter
  assign sign_a  = (op.mul_op != ooo_exec_pkg::MULHU);
  assign sign_b  = (op.mul_op == ooo_exec_pkg::MUL) || (op.mul_op == ooo_exec_pkg::MULH);
  assign a_ext   = {{`XLEN{sign_a & op.port_a[`XLEN-1]}}, op.port_a};
  assign b_ext   = {{`XLEN{sign_b & op.port_b[`XLEN-1]}}, op.port_b};
  assign product = a_ext * b_ext;

  // Stage valids, frozen while commit stalls
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stage_valid <= '0;
    end else if (flush) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[DEPTH-2:0], op.issue_mu};
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      stage_hi      <= {stage_hi[DEPTH-2:0], (op.mul_op != ooo_exec_pkg::MUL)};
      stage_prod[0] <= product;
      stage_rd[0]   <= op.reg_rd;
      stage_idx[0]  <= op.index;
      for (int i = 1; i < DEPTH; i++) begin
        stage_prod[i] <= stage_prod[i-1];
        stage_rd[i]   <= stage_rd[i-1];
        stage_idx[i]  <= stage_idx[i-1];
      end
    end
  end

  assign valid         = stage_valid[DEPTH-1];
  assign result.wdata  = stage_hi[DEPTH-1] ? stage_prod[DEPTH-1][PROD_W-1:`XLEN]
                                           : stage_prod[DEPTH-1][`XLEN-1:0];
  assign result.reg_rd = stage_rd[DEPTH-1];
  assign result.index  = stage_idx[DEPTH-1];
  assign busy_mu       = |stage_valid;

  // A result only appears after the stage before the output held an operation
  a_valid_has_source: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(valid) |-> $past(stage_valid[DEPTH-2]))
    else $error("multiply_unit: result valid without an operation in flight");

  a_idle_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !busy_mu)
    else $error("multiply_unit: busy right after reset");

endmodule

`default_nettype wire

// ==== logic/ooo_exec_cfg.svh ====
/* Width and latency settings for the execute stage.
   Included by the package and by any module that sizes logic from them. */
`ifndef OOO_EXEC_CFG_SVH
`define OOO_EXEC_CFG_SVH

// Data word width
`define XLEN 32

// Destination register address width
`define REG_ADDR_W 5

// Completion-buffer index width, 16 entries
`define CB_INDEX_W 4

// Multiply pipeline depth in stages
`define MUL_LATENCY 3

`endif

// ==== logic/ooo_exec_pkg.sv ====
/* Types shared by the execute stage units, latches and top level.
   Referenced by scoped name, sized from the cfg header. */
`default_nettype none

`include "ooo_exec_cfg.svh"

package ooo_exec_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CB_INDEX_W-1:0] cb_index_t;

  // Encodings are contiguous from zero
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_t;

  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    BLTU = 3'd4,
    BGEU = 3'd5
  } br_op_t;

  // Register writeback from the arithmetic unit
  typedef struct packed {
    word_t     wdata;
    reg_addr_t reg_rd;
    cb_index_t index;
  } au_result_t;

  // Register writeback from the multiply unit
  typedef struct packed {
    word_t     wdata;
    reg_addr_t reg_rd;
    cb_index_t index;
  } mu_result_t;

  // Predictor update and resolved target
  typedef struct packed {
    logic  is_jump;
    logic  taken;
    logic  prediction;
    word_t resolved_addr;
    word_t jump_addr;
    word_t pc4;
  } br_result_t;

endpackage

`default_nettype wire

// ==== logic/ooo_execute_top.sv ====
/* Execute stage top level of the out-of-order pipeline.
   Issued operation and hazard controls come in on plain ports, latched
   results for commit and the redirect signals for the hazard unit go out. */
`timescale 1ns/1ps
`default_nettype none

module ooo_execute_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    issue_au,
  input  logic                    issue_mu,
  input  logic                    issue_br,
  input  logic                    issue_jump,
  input  logic                    j_sel,
  input  logic                    prediction,
  input  ooo_exec_pkg::alu_op_t   alu_op,
  input  ooo_exec_pkg::mul_op_t   mul_op,
  input  ooo_exec_pkg::br_op_t    br_op,
  input  ooo_exec_pkg::word_t     port_a,
  input  ooo_exec_pkg::word_t     port_b,
  input  ooo_exec_pkg::word_t     pc,
  input  ooo_exec_pkg::word_t     imm,
  input  ooo_exec_pkg::reg_addr_t reg_rd,
  input  ooo_exec_pkg::cb_index_t index,
  input  logic                    stall_ex,
  input  logic                    stall_commit,
  input  logic                    flush,
  output logic                    mispredict,
  output ooo_exec_pkg::word_t     brj_addr,
  output logic                    busy_mu,
  output logic                    au_valid,
  output ooo_exec_pkg::word_t     au_wdata,
  output ooo_exec_pkg::reg_addr_t au_reg_rd,
  output ooo_exec_pkg::cb_index_t au_index,
  output logic                    mu_valid,
  output ooo_exec_pkg::word_t     mu_wdata,
  output ooo_exec_pkg::reg_addr_t mu_reg_rd,
  output ooo_exec_pkg::cb_index_t mu_index,
  output logic                    br_valid,
  output logic                    br_is_jump,
  output logic                    br_taken,
  output logic                    br_prediction,
  output ooo_exec_pkg::word_t     br_resolved_addr,
  output ooo_exec_pkg::word_t     br_jump_addr,
  output ooo_exec_pkg::word_t     br_pc4
);

  logic                     au_valid_d;
  logic                     mu_valid_d;
  logic                     br_valid_d;
  ooo_exec_pkg::au_result_t au_d;
  ooo_exec_pkg::au_result_t au_q;
  ooo_exec_pkg::mu_result_t mu_d;
  ooo_exec_pkg::mu_result_t mu_q;
  ooo_exec_pkg::br_result_t br_d;
  ooo_exec_pkg::br_result_t br_q;

  // Issued operation, fanned out to all units
  exec_op_if op_bus ();

  assign op_bus.issue_au   = issue_au;
  assign op_bus.issue_mu   = issue_mu;
  assign op_bus.issue_br   = issue_br;
  assign op_bus.issue_jump = issue_jump;
  assign op_bus.j_sel      = j_sel;
  assign op_bus.alu_op     = alu_op;
  assign op_bus.mul_op     = mul_op;
  assign op_bus.br_op      = br_op;
  assign op_bus.prediction = prediction;
  assign op_bus.port_a     = port_a;
  assign op_bus.port_b     = port_b;
  assign op_bus.pc         = pc;
  assign op_bus.imm        = imm;
  assign op_bus.reg_rd     = reg_rd;
  assign op_bus.index      = index;

  arith_unit u_arith (
    .op     (op_bus),
    .valid  (au_valid_d),
    .result (au_d)
  );

  branch_jump_res u_brj (
    .op         (op_bus),
    .valid      (br_valid_d),
    .result     (br_d),
    .mispredict (mispredict),
    .brj_addr   (brj_addr)
  );

  // Multiply pipeline moves in step with the commit latches
  multiply_unit u_mul (
    .CLK     (CLK),
    .nRST    (nRST),
    .op      (op_bus),
    .advance (~stall_commit),
    .flush   (flush),
    .valid   (mu_valid_d),
    .result  (mu_d),
    .busy_mu (busy_mu)
  );

  commit_latch #(.payload_t(ooo_exec_pkg::au_result_t)) u_au_latch (
    .CLK(CLK), .nRST(nRST), .stall_ex(stall_ex), .stall_commit(stall_commit),
    .flush(flush), .in_valid(au_valid_d), .in_data(au_d),
    .out_valid(au_valid), .out_data(au_q)
  );

  commit_latch #(.payload_t(ooo_exec_pkg::mu_result_t)) u_mu_latch (
    .CLK(CLK), .nRST(nRST), .stall_ex(stall_ex), .stall_commit(stall_commit),
    .flush(flush), .in_valid(mu_valid_d), .in_data(mu_d),
    .out_valid(mu_valid), .out_data(mu_q)
  );

  commit_latch #(.payload_t(ooo_exec_pkg::br_result_t)) u_br_latch (
    .CLK(CLK), .nRST(nRST), .stall_ex(stall_ex), .stall_commit(stall_commit),
    .flush(flush), .in_valid(br_valid_d), .in_data(br_d),
    .out_valid(br_valid), .out_data(br_q)
  );

  // Unpack latched records onto the commit ports
  assign au_wdata         = au_q.wdata;
  assign au_reg_rd        = au_q.reg_rd;
  assign au_index         = au_q.index;
  assign mu_wdata         = mu_q.wdata;
  assign mu_reg_rd        = mu_q.reg_rd;
  assign mu_index         = mu_q.index;
  assign br_is_jump       = br_q.is_jump;
  assign br_taken         = br_q.taken;
  assign br_prediction    = br_q.prediction;
  assign br_resolved_addr = br_q.resolved_addr;
  assign br_jump_addr     = br_q.jump_addr;
  assign br_pc4           = br_q.pc4;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
+incdir+verification
logic/ooo_exec_pkg.sv
logic/exec_op_if.sv
logic/arith_unit.sv
logic/branch_jump_res.sv
logic/multiply_unit.sv
logic/commit_latch.sv
logic/ooo_execute_top.sv
verification/tb_ooo_execute.sv

// ==== verification/exec_model.svh ====
/* Reference arithmetic for the execute stage and the typed compare tasks.
   Included inside the testbench module, after its check and error counters. */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic ooo_exec_pkg::word_t alu_ref(input ooo_exec_pkg::alu_op_t op,
                                                input ooo_exec_pkg::word_t a,
                                                input ooo_exec_pkg::word_t b);
  logic [4:0] sh;
  sh = b[4:0];
  case (op)
    ooo_exec_pkg::ADD:  return a + b;
    ooo_exec_pkg::SUB:  return a - b;
    ooo_exec_pkg::AND:  return a & b;
    ooo_exec_pkg::OR:   return a | b;
    ooo_exec_pkg::XOR:  return a ^ b;
    ooo_exec_pkg::SLL:  return a << sh;
    ooo_exec_pkg::SRL:  return a >> sh;
    ooo_exec_pkg::SRA:  return ooo_exec_pkg::word_t'(int'(a) >>> sh);
    ooo_exec_pkg::SLT:  return (int'(a) < int'(b)) ? 32'd1 : 32'd0;
    ooo_exec_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
    default:            return '0;
  endcase
endfunction

// Full 64-bit product, high or low word picked afterwards
function automatic ooo_exec_pkg::word_t mul_ref(input ooo_exec_pkg::mul_op_t op,
                                                input ooo_exec_pkg::word_t a,
                                                input ooo_exec_pkg::word_t b);
  longint p;
  case (op)
    ooo_exec_pkg::MULHSU: p = longint'(int'(a)) * longint'({32'd0, b});
    ooo_exec_pkg::MULHU:  p = longint'({32'd0, a}) * longint'({32'd0, b});
    default:              p = longint'(int'(a)) * longint'(int'(b));
  endcase
  return (op == ooo_exec_pkg::MUL) ? p[31:0] : p[63:32];
endfunction

function automatic logic branch_ref(input ooo_exec_pkg::br_op_t op,
                                    input ooo_exec_pkg::word_t a,
                                    input ooo_exec_pkg::word_t b);
  case (op)
    ooo_exec_pkg::BEQ:  return a == b;
    ooo_exec_pkg::BNE:  return a != b;
    ooo_exec_pkg::BLT:  return int'(a) < int'(b);
    ooo_exec_pkg::BGE:  return int'(a) >= int'(b);
    ooo_exec_pkg::BLTU: return a < b;
    default:            return a >= b;
  endcase
endfunction

// JALR style when sel is set, bit 0 always dropped
function automatic ooo_exec_pkg::word_t jump_ref(input logic sel, input ooo_exec_pkg::word_t a,
                                                 input ooo_exec_pkg::word_t pc_v,
                                                 input ooo_exec_pkg::word_t imm_v);
  ooo_exec_pkg::word_t t;
  t = (sel ? a : pc_v) + imm_v;
  t[0] = 1'b0;
  return t;
endfunction

task automatic check_hazard(input string name, input logic exp_mis,
                            input ooo_exec_pkg::word_t exp_addr, input logic exp_busy,
                            input logic act_mis, input ooo_exec_pkg::word_t act_addr,
                            input logic act_busy);
  checks++;
  if (act_mis !== exp_mis) begin
    errors++;
    $display("CHECK FAILED %s mispredict at %0t: expected %0b, actual %0b",
             name, $time, exp_mis, act_mis);
  end
  if (act_addr !== exp_addr) begin
    errors++;
    $display("CHECK FAILED %s brj_addr at %0t: expected %h, actual %h",
             name, $time, exp_addr, act_addr);
  end
  if (act_busy !== exp_busy) begin
    errors++;
    $display("CHECK FAILED %s busy_mu at %0t: expected %0b, actual %0b",
             name, $time, exp_busy, act_busy);
  end
endtask

task automatic check_au(input string name, input logic exp_valid,
                        input ooo_exec_pkg::au_result_t exp_r, input logic act_valid,
                        input ooo_exec_pkg::au_result_t act_r);
  checks++;
  if (act_valid !== exp_valid) begin
    errors++;
    $display("CHECK FAILED %s au_valid at %0t: expected %0b, actual %0b",
             name, $time, exp_valid, act_valid);
  end else if (exp_valid && act_r !== exp_r) begin
    errors++;
    $display("CHECK FAILED %s au result at %0t: expected %h, actual %h",
             name, $time, exp_r, act_r);
  end
endtask

task automatic check_mu(input string name, input logic exp_valid,
                        input ooo_exec_pkg::mu_result_t exp_r, input logic act_valid,
                        input ooo_exec_pkg::mu_result_t act_r);
  checks++;
  if (act_valid !== exp_valid) begin
    errors++;
    $display("CHECK FAILED %s mu_valid at %0t: expected %0b, actual %0b",
             name, $time, exp_valid, act_valid);
  end else if (exp_valid && act_r !== exp_r) begin
    errors++;
    $display("CHECK FAILED %s mu result at %0t: expected %h, actual %h",
             name, $time, exp_r, act_r);
  end
endtask

task automatic check_br(input string name, input logic exp_valid,
                        input ooo_exec_pkg::br_result_t exp_r, input logic act_valid,
                        input ooo_exec_pkg::br_result_t act_r);
  checks++;
  if (act_valid !== exp_valid) begin
    errors++;
    $display("CHECK FAILED %s br_valid at %0t: expected %0b, actual %0b",
             name, $time, exp_valid, act_valid);
  end else if (exp_valid && act_r !== exp_r) begin
    errors++;
    $display("CHECK FAILED %s br result at %0t: expected %h, actual %h",
             name, $time, exp_r, act_r);
  end
endtask

`endif

// ==== verification/tb_ooo_execute.sv ====
/* Random stimulus testbench for the execute stage top level.
   A cycle model of the latches and the multiply pipeline predicts every
   output, built and run through src.f. */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_exec_cfg.svh"

module tb_ooo_execute;

  localparam int RESET_CYCLES = 4;
  localparam int DRAIN_CYCLES = `MUL_LATENCY + 2;
  localparam int ALU_CYCLES   = 200;
  localparam int MUL_CYCLES   = 60;
  localparam int BR_CYCLES    = 200;
  localparam int JUMP_CYCLES  = 100;
  localparam int STALL_CYCLES = 150;
  localparam int FLUSH_CYCLES = 120;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 6 * DRAIN_CYCLES + ALU_CYCLES + MUL_CYCLES
                                + BR_CYCLES + JUMP_CYCLES + STALL_CYCLES + FLUSH_CYCLES;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 40 * 2;

  // Test kinds
  localparam int T_ALU   = 0;
  localparam int T_MUL   = 1;
  localparam int T_BR    = 2;
  localparam int T_JUMP  = 3;
  localparam int T_STALL = 4;
  localparam int T_FLUSH = 5;

  logic                    CLK;
  logic                    nRST;
  logic                    issue_au;
  logic                    issue_mu;
  logic                    issue_br;
  logic                    issue_jump;
  logic                    j_sel;
  logic                    prediction;
  ooo_exec_pkg::alu_op_t   alu_op;
  ooo_exec_pkg::mul_op_t   mul_op;
  ooo_exec_pkg::br_op_t    br_op;
  ooo_exec_pkg::word_t     port_a;
  ooo_exec_pkg::word_t     port_b;
  ooo_exec_pkg::word_t     pc;
  ooo_exec_pkg::word_t     imm;
  ooo_exec_pkg::reg_addr_t reg_rd;
  ooo_exec_pkg::cb_index_t index;
  logic                    stall_ex;
  logic                    stall_commit;
  logic                    flush;
  logic                    mispredict;
  ooo_exec_pkg::word_t     brj_addr;
  logic                    busy_mu;
  logic                    au_valid;
  ooo_exec_pkg::word_t     au_wdata;
  ooo_exec_pkg::reg_addr_t au_reg_rd;
  ooo_exec_pkg::cb_index_t au_index;
  logic                    mu_valid;
  ooo_exec_pkg::word_t     mu_wdata;
  ooo_exec_pkg::reg_addr_t mu_reg_rd;
  ooo_exec_pkg::cb_index_t mu_index;
  logic                    br_valid;
  logic                    br_is_jump;
  logic                    br_taken;
  logic                    br_prediction;
  ooo_exec_pkg::word_t     br_resolved_addr;
  ooo_exec_pkg::word_t     br_jump_addr;
  ooo_exec_pkg::word_t     br_pc4;

  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  logic [31:0] rng_state;

  // Expected latch contents and multiplies in flight, oldest first
  logic                     exp_au_valid;
  logic                     exp_mu_valid;
  logic                     exp_br_valid;
  ooo_exec_pkg::au_result_t exp_au;
  ooo_exec_pkg::mu_result_t exp_mu;
  ooo_exec_pkg::br_result_t exp_br;
  ooo_exec_pkg::mu_result_t mul_res[$];
  int                       mul_age[$];

  `include "exec_model.svh"

  ooo_execute_top i_dut (.*);

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] rand_below(input logic [31:0] n);
    return next_random() % n;
  endfunction

  function automatic logic random_bit();
    logic [31:0] r;
    r = next_random();
    return r[31];
  endfunction

  task automatic drive_idle();
    issue_au     = 1'b0;
    issue_mu     = 1'b0;
    issue_br     = 1'b0;
    issue_jump   = 1'b0;
    j_sel        = 1'b0;
    prediction   = 1'b0;
    alu_op       = ooo_exec_pkg::ADD;
    mul_op       = ooo_exec_pkg::MUL;
    br_op        = ooo_exec_pkg::BEQ;
    port_a       = '0;
    port_b       = '0;
    pc           = '0;
    imm          = '0;
    reg_rd       = '0;
    index        = '0;
    stall_ex     = 1'b0;
    stall_commit = 1'b0;
    flush        = 1'b0;
  endtask

  task automatic random_operands();
    alu_op     = ooo_exec_pkg::alu_op_t'(4'(rand_below(10)));
    mul_op     = ooo_exec_pkg::mul_op_t'(2'(rand_below(4)));
    br_op      = ooo_exec_pkg::br_op_t'(3'(rand_below(6)));
    j_sel      = random_bit();
    prediction = random_bit();
    port_a     = next_random();
    // Equal operands now and then for BEQ, BGE and SLT edges
    port_b     = (rand_below(4) == 0) ? port_a : next_random();
    pc         = next_random() & ~32'h3;
    imm        = next_random();
    reg_rd     = ooo_exec_pkg::reg_addr_t'(next_random());
    index      = ooo_exec_pkg::cb_index_t'(next_random());
  endtask

  // Any mix of ALU and multiply, plus at most one branch or jump
  task automatic random_issue();
    logic [31:0] pick;
    issue_au   = random_bit();
    issue_mu   = random_bit();
    pick       = rand_below(3);
    issue_br   = (pick == 1);
    issue_jump = (pick == 2);
  endtask

  task automatic hazard_expect(output logic mis, output ooo_exec_pkg::word_t addr);
    logic taken;
    taken = branch_ref(br_op, port_a, port_b);
    if (issue_jump) begin
      mis  = 1'b1;
      addr = jump_ref(j_sel, port_a, pc, imm);
    end else if (issue_br && (taken != prediction)) begin
      mis  = 1'b1;
      addr = pc + imm;
    end else begin
      mis  = 1'b0;
      addr = pc + 32'd4;
    end
  endtask

  function automatic ooo_exec_pkg::br_result_t br_expect();
    ooo_exec_pkg::br_result_t r;
    r.is_jump       = issue_jump;
    r.taken         = branch_ref(br_op, port_a, port_b);
    r.prediction    = prediction;
    r.resolved_addr = r.taken ? pc + imm : pc + 32'd4;
    r.jump_addr     = jump_ref(j_sel, port_a, pc, imm);
    r.pc4           = pc + 32'd4;
    return r;
  endfunction

  // Applies one rising edge to the expected state
  task automatic model_edge();
    logic                     mu_in_valid;
    ooo_exec_pkg::mu_result_t mu_in;
    mu_in_valid = (mul_age.size() > 0) && (mul_age[0] == `MUL_LATENCY);
    mu_in       = mu_in_valid ? mul_res[0] : '0;
    if (flush || (stall_ex && !stall_commit)) begin
      exp_au_valid = 1'b0;
      exp_mu_valid = 1'b0;
      exp_br_valid = 1'b0;
    end else if (!stall_commit) begin
      exp_au_valid = issue_au;
      exp_au       = {alu_ref(alu_op, port_a, port_b), reg_rd, index};
      exp_mu_valid = mu_in_valid;
      exp_mu       = mu_in;
      exp_br_valid = issue_br | issue_jump;
      exp_br       = br_expect();
    end
    if (flush) begin
      mul_res.delete();
      mul_age.delete();
    end else if (!stall_commit) begin
      if (mu_in_valid) begin
        void'(mul_res.pop_front());
        void'(mul_age.pop_front());
      end
      foreach (mul_age[i]) begin
        mul_age[i] = mul_age[i] + 1;
      end
      if (issue_mu) begin
        mul_res.push_back({mul_ref(mul_op, port_a, port_b), reg_rd, index});
        mul_age.push_back(1);
      end
    end
  endtask

  // Called 2 ns after a rising edge with the cycle's inputs in place
  task automatic run_cycle(input string name);
    logic                exp_mis;
    ooo_exec_pkg::word_t exp_addr;
    #18;
    hazard_expect(exp_mis, exp_addr);
    check_hazard(name, exp_mis, exp_addr, mul_age.size() != 0, mispredict, brj_addr, busy_mu);
    check_au(name, exp_au_valid, exp_au, au_valid, {au_wdata, au_reg_rd, au_index});
    check_mu(name, exp_mu_valid, exp_mu, mu_valid, {mu_wdata, mu_reg_rd, mu_index});
    check_br(name, exp_br_valid, exp_br, br_valid,
             {br_is_jump, br_taken, br_prediction, br_resolved_addr, br_jump_addr, br_pc4});
    @(posedge CLK);
    model_edge();
    #2;
    drive_idle();
  endtask

  task automatic run_test(input string name, input int kind, input int cycles);
    int errors_before;
    int stall_left;
    errors_before = errors;
    stall_left    = 0;
    for (int i = 0; i < cycles; i++) begin
      random_operands();
      case (kind)
        T_ALU:  issue_au = 1'b1;
        T_MUL:  issue_mu = 1'b1;
        T_BR:   issue_br = 1'b1;
        T_JUMP: issue_jump = 1'b1;
        T_STALL: begin
          if (stall_left == 0 && rand_below(5) == 0) begin
            stall_left = 1 + int'(rand_below(6));
          end
          // Nothing issues while the stage is held
          if (stall_left > 0) begin
            stall_commit = 1'b1;
            stall_left--;
          end else if (rand_below(8) == 0) begin
            // ALU and branch results issued here meet the bubble
            stall_ex = 1'b1;
            random_issue();
          end else begin
            random_issue();
          end
        end
        default: begin
          random_issue();
          flush = (rand_below(8) == 0);
        end
      endcase
      run_cycle(name);
    end
    repeat (DRAIN_CYCLES) run_cycle(name);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    CLK          = 1'b0;
    nRST         = 1'b0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'd61;
    exp_au_valid = 1'b0;
    exp_mu_valid = 1'b0;
    exp_br_valid = 1'b0;
    exp_au       = '0;
    exp_mu       = '0;
    exp_br       = '0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;
    run_test("alu_random", T_ALU, ALU_CYCLES);
    run_test("mul_back_to_back", T_MUL, MUL_CYCLES);
    run_test("branch_random", T_BR, BR_CYCLES);
    run_test("jump", T_JUMP, JUMP_CYCLES);
    run_test("stall", T_STALL, STALL_CYCLES);
    run_test("flush", T_FLUSH, FLUSH_CYCLES);
    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Twice the length of the whole test sequence
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
